// File: hdl/arp_pkg.sv
`default_nettype none

package arp_pkg;

  // ------------------------------------------------------------
  // Field types
  // ------------------------------------------------------------
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ipv4_addr_t;
  typedef logic [15:0] arp_oper_t;
  typedef logic [7:0]  arp_byte_t;

  // ------------------------------------------------------------
  // Protocol constants
  // ------------------------------------------------------------
  localparam arp_oper_t   ARP_OPER_REQUEST = 16'd1;
  localparam arp_oper_t   ARP_OPER_REPLY   = 16'd2;
  localparam logic [15:0] ARP_HTYPE_ETH    = 16'd1;
  localparam logic [15:0] ARP_PTYPE_IPV4   = 16'h0800;
  localparam arp_byte_t   ARP_HLEN         = 8'd6;
  localparam arp_byte_t   ARP_PLEN         = 8'd4;
  localparam int          ARP_PKT_BYTES    = 28;

  localparam mac_addr_t   MAC_BROADCAST    = '1;

  // Number of cache entries. Kept a power of two so the write pointer wraps.
  localparam int          ARP_TABLE_SIZE   = 4;
  localparam int          ARP_IDX_W        = $clog2(ARP_TABLE_SIZE);

  // ------------------------------------------------------------
  // State machines
  // ------------------------------------------------------------
  typedef enum logic [1:0] {
    FR_IDLE,
    FR_SEND,
    FR_DONE
  } framer_state_t;

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_GRANT,
    ARB_RELEASE
  } arb_state_t;

endpackage

`default_nettype wire

// File: hdl/arp_stream_if.sv
`timescale 1ns/10ps
`default_nettype none

interface arp_stream_if;
  import arp_pkg::*;

  logic      valid;
  arp_byte_t data;
  logic      sof;
  logic      eof;
  logic      ready;

  // A byte moves on an edge where valid and ready are both high.
  modport source (output valid, data, sof, eof, input ready);
  modport sink   (input valid, data, sof, eof, output ready);

endinterface

`default_nettype wire

// File: hdl/arp_tx_req_if.sv
`timescale 1ns/10ps
`default_nettype none

interface arp_tx_req_if;
  import arp_pkg::*;

  logic       req;
  arp_oper_t  oper;
  mac_addr_t  tha;
  ipv4_addr_t tpa;
  logic       ack;

  modport requester (output req, oper, tha, tpa, input ack);
  modport arbiter   (input req, oper, tha, tpa, output ack);

endinterface

`default_nettype wire

// File: hdl/arp_rx_parser.sv
`timescale 1ns/10ps
`default_nettype none

module arp_rx_parser (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                rx_valid,
  input  logic                rx_sof,
  input  logic                rx_eof,
  input  arp_pkg::arp_byte_t  rx_data,
  input  arp_pkg::ipv4_addr_t dev_ip,
  output logic                learn,
  output arp_pkg::ipv4_addr_t learn_ip,
  output arp_pkg::mac_addr_t  learn_mac,
  arp_tx_req_if.requester     reply
);
  import arp_pkg::*;

  logic [4:0]  cnt;
  logic [4:0]  idx;
  logic [15:0] htype_q;
  logic [15:0] ptype_q;
  arp_byte_t   hlen_q;
  arp_byte_t   plen_q;
  arp_oper_t   oper_q;
  mac_addr_t   sha_q;
  ipv4_addr_t  spa_q;
  ipv4_addr_t  tpa_q;
  ipv4_addr_t  tpa_full;
  logic        pkt_ok;
  logic        reply_set;
  logic        req_q;

  // The sof byte is always byte zero, whatever the counter holds.
  assign idx      = rx_sof ? 5'd0 : cnt;
  // The last target IP byte is still on the bus when eof is accepted.
  assign tpa_full = {tpa_q[23:0], rx_data};

  assign pkt_ok = rx_valid && rx_eof && (idx == 5'(ARP_PKT_BYTES - 1)) &&
                  (htype_q == ARP_HTYPE_ETH) && (ptype_q == ARP_PTYPE_IPV4) &&
                  (hlen_q == ARP_HLEN) && (plen_q == ARP_PLEN);

  assign reply_set = pkt_ok && (oper_q == ARP_OPER_REQUEST) && (tpa_full == dev_ip) &&
                     !req_q && !reply.ack;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt   <= '0;
      learn <= 1'b0;
      req_q <= 1'b0;
    end else begin
      learn <= pkt_ok;
      if (rx_valid) begin
        cnt <= (idx == 5'd31) ? idx : idx + 5'd1;
      end
      if (req_q && reply.ack) begin
        req_q <= 1'b0;
      end else if (reply_set) begin
        req_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_valid) begin
      case (idx) inside
        [5'd0:5'd1]:   htype_q <= {htype_q[7:0], rx_data};
        [5'd2:5'd3]:   ptype_q <= {ptype_q[7:0], rx_data};
        5'd4:          hlen_q  <= rx_data;
        5'd5:          plen_q  <= rx_data;
        [5'd6:5'd7]:   oper_q  <= {oper_q[7:0], rx_data};
        [5'd8:5'd13]:  sha_q   <= {sha_q[39:0], rx_data};
        [5'd14:5'd17]: spa_q   <= {spa_q[23:0], rx_data};
        [5'd24:5'd27]: tpa_q   <= {tpa_q[23:0], rx_data};
        default: ;
      endcase
    end
    if (reply_set) begin
      reply.tha <= sha_q;
      reply.tpa <= spa_q;
    end
  end

  // Sender fields stay put until byte 8 of a following packet.
  assign learn_ip   = spa_q;
  assign learn_mac  = sha_q;
  assign reply.req  = req_q;
  assign reply.oper = ARP_OPER_REPLY;

endmodule

`default_nettype wire

// File: hdl/arp_cache.sv
`timescale 1ns/10ps
`default_nettype none

module arp_cache (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                learn,
  input  arp_pkg::ipv4_addr_t learn_ip,
  input  arp_pkg::mac_addr_t  learn_mac,
  input  logic                lookup_req,
  input  arp_pkg::ipv4_addr_t lookup_ip,
  output logic                lookup_ack,
  output logic                lookup_hit,
  output arp_pkg::mac_addr_t  lookup_mac,
  arp_tx_req_if.requester     request
);
  import arp_pkg::*;

  logic [ARP_TABLE_SIZE-1:0] vld;
  ipv4_addr_t                ip_tbl  [ARP_TABLE_SIZE];
  mac_addr_t                 mac_tbl [ARP_TABLE_SIZE];

  logic [ARP_IDX_W-1:0] wr_ptr;
  logic [ARP_IDX_W-1:0] lm_idx;
  logic [ARP_IDX_W-1:0] wr_idx;
  logic                 lm_hit;
  logic                 lk_hit;
  mac_addr_t            lk_mac;
  logic                 lk_start;
  logic                 miss_send;
  logic                 req_q;

  // ------------------------------------------------------------
  // Match logic for learning and lookup
  // ------------------------------------------------------------
  always_comb begin
    lm_hit = 1'b0;
    lm_idx = '0;
    lk_hit = 1'b0;
    lk_mac = '0;
    for (int i = 0; i < ARP_TABLE_SIZE; i++) begin
      if (vld[i] && (ip_tbl[i] == learn_ip)) begin
        lm_hit = 1'b1;
        lm_idx = i[ARP_IDX_W-1:0];
      end
      if (vld[i] && (ip_tbl[i] == lookup_ip)) begin
        lk_hit = 1'b1;
        lk_mac = mac_tbl[i];
      end
    end
    // A learn in the same cycle wins over the stored entry.
    if (learn && (learn_ip == lookup_ip)) begin
      lk_hit = 1'b1;
      lk_mac = learn_mac;
    end
  end

  assign wr_idx    = lm_hit ? lm_idx : wr_ptr;
  assign lk_start  = lookup_req && !lookup_ack;
  assign miss_send = lk_start && !lk_hit && !req_q && !request.ack;

  // ------------------------------------------------------------
  // Control state
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld        <= '0;
      wr_ptr     <= '0;
      lookup_ack <= 1'b0;
      lookup_hit <= 1'b0;
      req_q      <= 1'b0;
    end else begin
      if (learn) begin
        vld[wr_idx] <= 1'b1;
        if (!lm_hit) begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
      if (lk_start) begin
        lookup_ack <= 1'b1;
        lookup_hit <= lk_hit;
      end else if (!lookup_req) begin
        lookup_ack <= 1'b0;
      end
      if (req_q && request.ack) begin
        req_q <= 1'b0;
      end else if (miss_send) begin
        req_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (learn) begin
      ip_tbl[wr_idx]  <= learn_ip;
      mac_tbl[wr_idx] <= learn_mac;
    end
    if (lk_start) begin
      lookup_mac <= lk_mac;
    end
    if (miss_send) begin
      request.tpa <= lookup_ip;
    end
  end

  assign request.req  = req_q;
  assign request.oper = ARP_OPER_REQUEST;
  assign request.tha  = '0;

endmodule

`default_nettype wire

// File: hdl/arp_tx_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module arp_tx_arbiter (
  input  logic                clk,
  input  logic                rst_n,
  arp_tx_req_if.arbiter       reply,
  arp_tx_req_if.arbiter       request,
  output logic                start,
  output arp_pkg::arp_oper_t  oper,
  output arp_pkg::mac_addr_t  tha,
  output arp_pkg::ipv4_addr_t tpa,
  input  logic                frame_done
);
  import arp_pkg::*;

  arb_state_t state;
  logic       sel;
  logic       pick;
  logic       reply_ack_q;
  logic       request_ack_q;

  // sel holds the source served last, 0 for reply and 1 for request.
  assign pick  = request.req && (!reply.req || !sel);
  assign start = (state == ARB_IDLE) && (reply.req || request.req);

  assign oper = pick ? request.oper : reply.oper;
  assign tha  = pick ? request.tha  : reply.tha;
  assign tpa  = pick ? request.tpa  : reply.tpa;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= ARB_IDLE;
      sel           <= 1'b0;
      reply_ack_q   <= 1'b0;
      request_ack_q <= 1'b0;
    end else begin
      case (state)
        ARB_IDLE: begin
          if (start) begin
            sel   <= pick;
            state <= ARB_GRANT;
          end
        end
        ARB_GRANT: begin
          if (frame_done) begin
            reply_ack_q   <= !sel;
            request_ack_q <= sel;
            state         <= ARB_RELEASE;
          end
        end
        ARB_RELEASE: begin
          if (sel ? !request.req : !reply.req) begin
            reply_ack_q   <= 1'b0;
            request_ack_q <= 1'b0;
            state         <= ARB_IDLE;
          end
        end
        default: state <= ARB_IDLE;
      endcase
    end
  end

  assign reply.ack   = reply_ack_q;
  assign request.ack = request_ack_q;

endmodule

`default_nettype wire

// File: hdl/arp_tx_framer.sv
`timescale 1ns/10ps
`default_nettype none

module arp_tx_framer (
  input  logic                clk,
  input  logic                rst_n,
  input  arp_pkg::mac_addr_t  dev_mac,
  input  arp_pkg::ipv4_addr_t dev_ip,
  input  logic                start,
  input  arp_pkg::arp_oper_t  oper,
  input  arp_pkg::mac_addr_t  tha,
  input  arp_pkg::ipv4_addr_t tpa,
  output logic                frame_done,
  arp_stream_if.source        tx
);
  import arp_pkg::*;

  localparam int PKT_W = ARP_PKT_BYTES * 8;

  framer_state_t    state;
  logic [4:0]       cnt;
  logic [PKT_W-1:0] pkt;

  // ------------------------------------------------------------
  // Sequencing
  // ------------------------------------------------------------
  // FR_SEND covers bytes 0 to 26. FR_DONE presents the eof byte.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= FR_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        FR_IDLE: begin
          if (start) begin
            cnt   <= '0;
            state <= FR_SEND;
          end
        end
        FR_SEND: begin
          if (tx.ready) begin
            cnt <= cnt + 5'd1;
            if (cnt == 5'(ARP_PKT_BYTES - 2)) begin
              state <= FR_DONE;
            end
          end
        end
        FR_DONE: begin
          if (tx.ready) begin
            state <= FR_IDLE;
          end
        end
        default: state <= FR_IDLE;
      endcase
    end
  end

  // The packet is loaded whole and shifted out from the top byte.
  always_ff @(posedge clk) begin
    if ((state == FR_IDLE) && start) begin
      pkt <= {ARP_HTYPE_ETH, ARP_PTYPE_IPV4, ARP_HLEN, ARP_PLEN,
              oper, dev_mac, dev_ip, tha, tpa};
    end else if ((state == FR_SEND) && tx.ready) begin
      pkt <= {pkt[PKT_W-9:0], 8'h00};
    end
  end

  assign tx.valid   = (state != FR_IDLE);
  assign tx.data    = pkt[PKT_W-1 -: 8];
  assign tx.sof     = (state == FR_SEND) && (cnt == 5'd0);
  assign tx.eof     = (state == FR_DONE);
  assign frame_done = (state == FR_DONE) && tx.ready;

endmodule

`default_nettype wire

// File: hdl/arp_top.sv
`timescale 1ns/10ps
`default_nettype none

module arp_top (
  input  logic                clk,
  input  logic                rst_n,
  input  arp_pkg::mac_addr_t  dev_mac,
  input  arp_pkg::ipv4_addr_t dev_ip,
  input  logic                rx_valid,
  input  arp_pkg::arp_byte_t  rx_data,
  input  logic                rx_sof,
  input  logic                rx_eof,
  output logic                tx_valid,
  output arp_pkg::arp_byte_t  tx_data,
  output logic                tx_sof,
  output logic                tx_eof,
  input  logic                tx_ready,
  input  logic                lookup_req,
  input  arp_pkg::ipv4_addr_t lookup_ip,
  output logic                lookup_ack,
  output logic                lookup_hit,
  output arp_pkg::mac_addr_t  lookup_mac
);
  import arp_pkg::*;

  logic       learn;
  ipv4_addr_t learn_ip;
  mac_addr_t  learn_mac;
  logic       start;
  arp_oper_t  oper;
  mac_addr_t  tha;
  ipv4_addr_t tpa;
  logic       frame_done;

  arp_stream_if tx_if ();
  arp_tx_req_if reply_if ();
  arp_tx_req_if request_if ();

  arp_rx_parser u_parser (
    .clk(clk), .rst_n(rst_n), .rx_valid(rx_valid), .rx_sof(rx_sof),
    .rx_eof(rx_eof), .rx_data(rx_data), .dev_ip(dev_ip), .learn(learn),
    .learn_ip(learn_ip), .learn_mac(learn_mac), .reply(reply_if.requester)
  );

  arp_cache u_cache (
    .clk(clk), .rst_n(rst_n), .learn(learn), .learn_ip(learn_ip),
    .learn_mac(learn_mac), .lookup_req(lookup_req), .lookup_ip(lookup_ip),
    .lookup_ack(lookup_ack), .lookup_hit(lookup_hit), .lookup_mac(lookup_mac),
    .request(request_if.requester)
  );

  arp_tx_arbiter u_arbiter (
    .clk(clk), .rst_n(rst_n), .reply(reply_if.arbiter), .request(request_if.arbiter),
    .start(start), .oper(oper), .tha(tha), .tpa(tpa), .frame_done(frame_done)
  );

  arp_tx_framer u_framer (
    .clk(clk), .rst_n(rst_n), .dev_mac(dev_mac), .dev_ip(dev_ip), .start(start),
    .oper(oper), .tha(tha), .tpa(tpa), .frame_done(frame_done), .tx(tx_if.source)
  );

  assign tx_valid    = tx_if.valid;
  assign tx_data     = tx_if.data;
  assign tx_sof      = tx_if.sof;
  assign tx_eof      = tx_if.eof;
  assign tx_if.ready = tx_ready;

endmodule

`default_nettype wire

// File: dv/arp_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module arp_assertions (
  input logic       clk,
  input logic       rst_n,
  input logic       tx_valid,
  input logic [7:0] tx_data,
  input logic       tx_ready,
  input logic       lookup_req,
  input logic       lookup_ack,
  input logic       reply_req,
  input logic       reply_ack,
  input logic       request_req,
  input logic       request_ack
);

  // Four-phase order on both transmit requesters.
  a_reply_req: assert property (@(posedge clk) disable iff (!rst_n)
    ($rose(reply_req) |-> !reply_ack) and ($fell(reply_req) |-> reply_ack))
    else $error("reply req out of order");

  a_reply_ack: assert property (@(posedge clk) disable iff (!rst_n)
    ($rose(reply_ack) |-> reply_req) and ($fell(reply_ack) |-> !reply_req))
    else $error("reply ack out of order");

  a_request_req: assert property (@(posedge clk) disable iff (!rst_n)
    ($rose(request_req) |-> !request_ack) and ($fell(request_req) |-> request_ack))
    else $error("request req out of order");

  a_request_ack: assert property (@(posedge clk) disable iff (!rst_n)
    ($rose(request_ack) |-> request_req) and ($fell(request_ack) |-> !request_req))
    else $error("request ack out of order");

  a_tx_hold: assert property (@(posedge clk) disable iff (!rst_n)
    tx_valid && !tx_ready |=> tx_valid && $stable(tx_data))
    else $error("tx byte changed while stalled");

  // The ack may linger for one cycle after req falls.
  a_lookup_ack: assert property (@(posedge clk) disable iff (!rst_n)
    lookup_ack && !lookup_req |=> !lookup_ack)
    else $error("lookup ack high without lookup req");

endmodule

`default_nettype wire

// File: dv/arp_checker.sv
`timescale 1ns/10ps
`default_nettype none

module arp_checker (
  input logic                clk,
  input logic                rst_n,
  input arp_pkg::mac_addr_t  dev_mac,
  input arp_pkg::ipv4_addr_t dev_ip,
  input logic                tx_valid,
  input arp_pkg::arp_byte_t  tx_data,
  input logic                tx_sof,
  input logic                tx_eof,
  input logic                tx_ready,
  input logic                lookup_ack,
  input logic                lookup_hit,
  input arp_pkg::mac_addr_t  lookup_mac
);
  import arp_pkg::*;

  arp_oper_t  exp_oper   [$];
  mac_addr_t  exp_tha    [$];
  ipv4_addr_t exp_tpa    [$];
  ipv4_addr_t exp_lk_ip  [$];
  logic       exp_lk_hit [$];
  mac_addr_t  exp_lk_mac [$];

  arp_byte_t got [32];
  int        nbytes   = 0;
  logic      in_frame = 1'b0;
  logic      ack_q;
  int        errors   = 0;
  int        checks   = 0;

  task automatic expect_frame(input arp_oper_t oper, input mac_addr_t tha,
                              input ipv4_addr_t tpa);
    exp_oper.push_back(oper);
    exp_tha.push_back(tha);
    exp_tpa.push_back(tpa);
  endtask

  task automatic expect_lookup(input ipv4_addr_t ip, input logic hit, input mac_addr_t mac);
    exp_lk_ip.push_back(ip);
    exp_lk_hit.push_back(hit);
    exp_lk_mac.push_back(mac);
  endtask

  function automatic int frames_pending();
    return exp_oper.size();
  endfunction

  function automatic int lookups_pending();
    return exp_lk_ip.size();
  endfunction

  // ------------------------------------------------------------
  // Frame comparison
  // ------------------------------------------------------------
  task automatic compare_frame();
    logic [223:0] exp;
    int           bad;
    exp = {16'h0001, 16'h0800, 8'h06, 8'h04, exp_oper[0], dev_mac, dev_ip,
           exp_tha[0], exp_tpa[0]};
    bad = 0;
    checks++;
    if (nbytes != 28) begin
      bad++;
      $display("[ERROR] %0t: frame has %0d bytes, expected 28", $time, nbytes);
    end else begin
      for (int i = 0; i < 28; i++) begin
        if (got[i] !== exp[223 - 8*i -: 8]) begin
          bad++;
          $display("[ERROR] %0t: frame byte %0d is %h, expected %h",
                   $time, i, got[i], exp[223 - 8*i -: 8]);
        end
      end
    end
    errors += (bad != 0);
    $display("frame oper %0d tpa %h: %s", exp_oper[0], exp_tpa[0], (bad == 0) ? "ok" : "FAILED");
    void'(exp_oper.pop_front());
    void'(exp_tha.pop_front());
    void'(exp_tpa.pop_front());
  endtask

  always @(posedge clk) begin
    if (rst_n && tx_valid && tx_ready) begin
      if (tx_sof) begin
        nbytes   = 0;
        in_frame = (exp_oper.size() != 0);
        if (!in_frame) begin
          errors++;
          $display("[ERROR] %0t: a frame started while none was expected", $time);
        end
      end else if (!in_frame) begin
        errors++;
        $display("[ERROR] %0t: byte %h sent outside a frame", $time, tx_data);
      end
      if (in_frame && nbytes < 32) begin
        got[nbytes] = tx_data;
        nbytes++;
      end
      if (tx_eof && in_frame) begin
        compare_frame();
        in_frame = 1'b0;
      end
    end
  end

  // ------------------------------------------------------------
  // Lookup comparison
  // ------------------------------------------------------------
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= lookup_ack;
      if (lookup_ack && !ack_q) begin
        checks++;
        if (exp_lk_ip.size() == 0) begin
          errors++;
          $display("a lookup was answered while none was expected");
        end else if (lookup_hit !== exp_lk_hit[0] ||
                     (exp_lk_hit[0] && lookup_mac !== exp_lk_mac[0])) begin
          errors++;
          $display("[ERROR] %0t: lookup %h got hit %b mac %h, expected hit %b mac %h",
                   $time, exp_lk_ip[0], lookup_hit, lookup_mac, exp_lk_hit[0],
                   exp_lk_mac[0]);
        end else begin
          $display("lookup %h hit %b: ok", exp_lk_ip[0], lookup_hit);
        end
        if (exp_lk_ip.size() != 0) begin
          void'(exp_lk_ip.pop_front());
          void'(exp_lk_hit.pop_front());
          void'(exp_lk_mac.pop_front());
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: dv/arp_tb.sv
`timescale 1ns/10ps
`default_nettype none

module arp_tb;
  import arp_pkg::*;

  localparam int MAX_RECS = 64;
  localparam int CYCLES_PER_REC = 200;

  logic       clk;
  logic       rst_n;
  mac_addr_t  dev_mac;
  ipv4_addr_t dev_ip;
  logic       rx_valid;
  arp_byte_t  rx_data;
  logic       rx_sof;
  logic       rx_eof;
  logic       tx_valid;
  arp_byte_t  tx_data;
  logic       tx_sof;
  logic       tx_eof;
  logic       tx_ready;
  logic       lookup_req;
  ipv4_addr_t lookup_ip;
  logic       lookup_ack;
  logic       lookup_hit;
  mac_addr_t  lookup_mac;

  string       rec_kind [MAX_RECS];
  logic [47:0] rec_f    [MAX_RECS][10];
  int          nrec;
  logic        parsed;
  logic        trace_ok;
  int          tb_errors;
  int          total_errors;

  arp_top dut (.*);

  arp_checker u_chk (
    .clk(clk), .rst_n(rst_n), .dev_mac(dev_mac), .dev_ip(dev_ip),
    .tx_valid(tx_valid), .tx_data(tx_data), .tx_sof(tx_sof), .tx_eof(tx_eof),
    .tx_ready(tx_ready), .lookup_ack(lookup_ack), .lookup_hit(lookup_hit),
    .lookup_mac(lookup_mac)
  );

  bind arp_top arp_assertions u_assert (
    .clk(clk), .rst_n(rst_n), .tx_valid(tx_valid), .tx_data(tx_data),
    .tx_ready(tx_ready), .lookup_req(lookup_req), .lookup_ack(lookup_ack),
    .reply_req(reply_if.req), .reply_ack(reply_if.ack),
    .request_req(request_if.req), .request_ack(request_if.ack)
  );

  always #2 clk = ~clk;

  // Random back-pressure, three cycles in four ready.
  initial begin
    void'($urandom(32'h197b_897d));
    forever begin
      @(posedge clk);
      #1;
      tx_ready = ($urandom % 4) != 0;
    end
  end

  // ------------------------------------------------------------
  // Trace reading
  // ------------------------------------------------------------
  task automatic read_trace(output logic ok);
    int    fd;
    int    code;
    string tok;
    string line;
    ok = 1'b0;
    nrec = 0;
    fd = $fopen("dv/arp_trace.txt", "r");
    if (fd == 0) begin
      $display("cannot open the trace file dv/arp_trace.txt");
    end else begin
      while (!$feof(fd) && nrec < MAX_RECS) begin
        code = $fscanf(fd, "%s", tok);
        if (code != 1) break;
        if (tok[0] == 8'h23) begin
          code = $fgets(line, fd);
        end else begin
          rec_kind[nrec] = tok;
          case (tok)
            "dev": code = $fscanf(fd, "%h %h", rec_f[nrec][0], rec_f[nrec][1]);
            "rx":  code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %d",
                                  rec_f[nrec][0], rec_f[nrec][1], rec_f[nrec][2],
                                  rec_f[nrec][3], rec_f[nrec][4], rec_f[nrec][5],
                                  rec_f[nrec][6], rec_f[nrec][7], rec_f[nrec][8],
                                  rec_f[nrec][9]);
            "lk":  code = $fscanf(fd, "%h %h %h", rec_f[nrec][0], rec_f[nrec][1],
                                  rec_f[nrec][2]);
            "tx":  code = $fscanf(fd, "%h %h %h", rec_f[nrec][0], rec_f[nrec][1],
                                  rec_f[nrec][2]);
            default: ;
          endcase
          nrec++;
        end
      end
      $fclose(fd);
      ok = (nrec > 0) && (rec_kind[0] == "dev");
      if (!ok) begin
        $display("trace file does not start with a dev record");
      end
    end
  endtask

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------
  task automatic send_packet(input int r);
    logic [223:0] pkt;
    int           len;
    pkt = {rec_f[r][0][15:0], rec_f[r][1][15:0], rec_f[r][2][7:0], rec_f[r][3][7:0],
           rec_f[r][4][15:0], rec_f[r][5], rec_f[r][6][31:0], rec_f[r][7],
           rec_f[r][8][31:0]};
    len = int'(rec_f[r][9]);
    for (int i = 0; i < len; i++) begin
      @(posedge clk);
      #1;
      rx_valid = 1'b1;
      rx_sof   = (i == 0);
      rx_eof   = (i == len - 1);
      rx_data  = (i < 28) ? pkt[223 - 8*i -: 8] : 8'h00;
    end
    @(posedge clk);
    #1;
    rx_valid = 1'b0;
    rx_sof   = 1'b0;
    rx_eof   = 1'b0;
  endtask

  task automatic do_lookup(input int r);
    u_chk.expect_lookup(rec_f[r][0][31:0], rec_f[r][1][0], rec_f[r][2]);
    @(posedge clk);
    #1;
    lookup_req = 1'b1;
    lookup_ip  = rec_f[r][0][31:0];
    forever begin
      @(posedge clk);
      #1;
      if (lookup_ack) break;
    end
    lookup_req = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (!lookup_ack) break;
    end
  endtask

  // Waits for every expected frame, then idles so a stray frame would show.
  task automatic settle();
    while (u_chk.frames_pending() != 0) begin
      @(posedge clk);
    end
    repeat (40) @(posedge clk);
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    dev_mac    = '0;
    dev_ip     = '0;
    rx_valid   = 1'b0;
    rx_data    = '0;
    rx_sof     = 1'b0;
    rx_eof     = 1'b0;
    tx_ready   = 1'b0;
    lookup_req = 1'b0;
    lookup_ip  = '0;
    tb_errors  = 0;
    parsed     = 1'b0;
    read_trace(trace_ok);
    if (!trace_ok) begin
      tb_errors++;
    end else begin
      dev_mac = rec_f[0][0];
      dev_ip  = rec_f[0][1][31:0];
      parsed  = 1'b1;
      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;
      for (int r = 1; r < nrec; r++) begin
        case (rec_kind[r])
          "rx":   send_packet(r);
          "lk":   do_lookup(r);
          "tx":   u_chk.expect_frame(rec_f[r][0][15:0], rec_f[r][1], rec_f[r][2][31:0]);
          "sync": settle();
          default: begin
            tb_errors++;
            $display("unknown trace record kind %s", rec_kind[r]);
          end
        endcase
      end
      settle();
      if (u_chk.lookups_pending() != 0) begin
        tb_errors++;
        $display("expected lookup responses never arrived");
      end
    end
    total_errors = tb_errors + u_chk.errors;
    $display("tests %0d, errors %0d", u_chk.checks, total_errors);
    if (total_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Watchdog sized from the number of trace records.
  initial begin
    wait (parsed);
    repeat (CYCLES_PER_REC * nrec) @(posedge clk);
    $display("timeout after %0d cycles", CYCLES_PER_REC * nrec);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/arp_trace.txt
# dev mac ip | rx htype ptype hlen plen oper sha spa tha tpa nbytes(decimal) | sync
# lk ip hit mac | tx oper tha tpa, an expected frame listed before its stimulus
dev 020000000001 c0a80001
tx 2 aabbcc000001 c0a80010
rx 1 800 6 4 1 aabbcc000001 c0a80010 0 c0a80001 28
sync
rx 1 800 6 4 1 aabbcc000002 c0a80020 0 c0a80099 28
sync
lk c0a80020 1 aabbcc000002
tx 1 0 c0a80077
lk c0a80077 0 0
sync
rx 1 800 6 4 2 aabbcc0000ff c0a80010 020000000001 c0a80001 28
sync
lk c0a80010 1 aabbcc0000ff
rx 1 800 6 4 1 aabbcc000003 c0a80030 0 c0a80099 28
rx 1 800 6 4 1 aabbcc000004 c0a80040 0 c0a80099 28
rx 1 800 6 4 1 aabbcc000005 c0a80050 0 c0a80099 28
sync
lk c0a80020 1 aabbcc000002
tx 1 0 c0a80010
lk c0a80010 0 0
sync
rx 2 800 6 4 1 aabbcc0000e1 c0a800e1 0 c0a80001 28
rx 1 806 6 4 1 aabbcc0000e2 c0a800e2 0 c0a80001 28
rx 1 800 6 4 1 aabbcc0000e3 c0a800e3 0 c0a80001 27
rx 1 800 5 4 1 aabbcc0000e4 c0a800e4 0 c0a80001 28
sync
tx 1 0 c0a800e1
lk c0a800e1 0 0
sync
tx 2 aabbcc000006 c0a80060
tx 1 0 c0a80088
rx 1 800 6 4 1 aabbcc000006 c0a80060 0 c0a80001 28
lk c0a80088 0 0
sync

// File: src.f
hdl/arp_pkg.sv
hdl/arp_stream_if.sv
hdl/arp_tx_req_if.sv
hdl/arp_rx_parser.sv
hdl/arp_cache.sv
hdl/arp_tx_arbiter.sv
hdl/arp_tx_framer.sv
hdl/arp_top.sv
dv/arp_assertions.sv
dv/arp_checker.sv
dv/arp_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -sv -Wno-fatal -f src.f --top-module arp_tb -o arp_sim
./obj_dir/arp_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "sim passed" sim.log; then
  exit 0
else
  exit 1
fi
